// ==== source/compact_config.svh ====
`ifndef COMPACT_CONFIG_SVH
`define COMPACT_CONFIG_SVH

// element format is q4.16, signed
`define COMPACT_INT_BITS 4
`define COMPACT_FRAC_BITS 16

// elements per vector
// one element is scanned per clock, so this is also the scan length
`define COMPACT_LANES 16

`endif

// ==== source/compact_pkg.sv ====
`include "compact_config.svh"

package compact_pkg;

	localparam int ELEM_W = `COMPACT_INT_BITS + `COMPACT_FRAC_BITS;

	// one activation or weight in fixed point
	typedef logic signed [ELEM_W-1:0] elem_t;

	// scan position or output slot pointer
	typedef logic [$clog2(`COMPACT_LANES)-1:0] idx_t;

	typedef enum logic [1:0] {
		ST_IDLE, // waiting for a frame
		ST_SCAN, // walking the frame one element per clock
		ST_HOLD  // result held until the consumer takes it
	} scan_state_e;

endpackage

// ==== source/scan_fsm.sv ====
`timescale 1ns/1ps

module scan_fsm
	import compact_pkg::*;
(
	clk,
	reset,
	i_in_valid,
	i_out_taken,
	i_last,
	o_in_ready,
	o_out_valid,
	o_capture,
	o_step,
	o_release
);

input clk, reset;
input i_in_valid;
input i_out_taken;
input i_last;

output logic o_in_ready;
output logic o_out_valid;
output logic o_capture;
output logic o_step;
output logic o_release;

scan_state_e state;
scan_state_e next_state;

logic accept; // frame handed over this cycle
logic take;   // result handed over this cycle

assign accept = (state == ST_IDLE) && i_in_valid;
assign take = (state == ST_HOLD) && i_out_taken;

always_ff @(posedge clk) begin
	if (reset) begin
		state <= ST_IDLE;
	end
	else begin
		state <= next_state;
	end
end

always_comb begin
	next_state = state;
	case (state)
		ST_IDLE: begin
			if (accept) begin
				next_state = ST_SCAN;
			end
		end
		ST_SCAN: begin
			// the final lane is written on this same edge
			if (i_last) begin
				next_state = ST_HOLD;
			end
		end
		ST_HOLD: begin
			if (take) begin
				next_state = ST_IDLE;
			end
		end
		default: begin
			next_state = ST_IDLE;
		end
	endcase
end

assign o_in_ready = (state == ST_IDLE);
assign o_out_valid = (state == ST_HOLD);
assign o_capture = accept;
assign o_step = (state == ST_SCAN); // high for the whole scan
assign o_release = take;

endmodule

// ==== source/scan_counter.sv ====
`timescale 1ns/1ps
`include "compact_config.svh"

module scan_counter
	import compact_pkg::*;
(
	clk,
	reset,
	i_clear,
	i_step,
	o_index,
	o_last
);

input clk, reset;
input i_clear;
input i_step;

output idx_t o_index;
output logic o_last;

always_ff @(posedge clk) begin
	if (reset) begin
		o_index <= '0;
	end
	else if (i_clear) begin
		o_index <= '0; // first scan cycle sees lane 0
	end
	else if (i_step) begin
		o_index <= o_index + 1'b1; // wraps to 0 after the final lane
	end
end

// flags the final lane so the fsm can leave the scan
assign o_last = (o_index == idx_t'(`COMPACT_LANES - 1));

endmodule

// ==== source/operand_buffer.sv ====
`timescale 1ns/1ps
`include "compact_config.svh"

module operand_buffer
	import compact_pkg::*;
(
	clk,
	reset,
	i_capture,
	i_frame,
	i_index,
	o_elem
);

input clk, reset;
input i_capture;
input elem_t i_frame [`COMPACT_LANES];
input idx_t i_index;

output elem_t o_elem;

elem_t frame_q [`COMPACT_LANES];

// whole vector is taken in one clock at acceptance
always_ff @(posedge clk) begin
	if (reset) begin
		for (int i = 0; i < `COMPACT_LANES; i++) begin
			frame_q[i] <= '0;
		end
	end
	else if (i_capture) begin
		for (int i = 0; i < `COMPACT_LANES; i++) begin
			frame_q[i] <= i_frame[i];
		end
	end
end

// element under scan, read without a register stage
assign o_elem = frame_q[i_index];

endmodule

// ==== source/zero_compactor.sv ====
`timescale 1ns/1ps
`include "compact_config.svh"

module zero_compactor
	import compact_pkg::*;
(
	clk,
	reset,
	i_step,
	i_release,
	i_elem,
	o_slots
);

input clk, reset;
input i_step;
input i_release;
input elem_t i_elem;

output elem_t o_slots [`COMPACT_LANES];

idx_t wr_ptr; // next free slot
logic elem_nz;
logic do_write;

assign elem_nz = (i_elem != '0);
assign do_write = i_step && elem_nz;

// slots after the last nonzero element keep their cleared value
always_ff @(posedge clk) begin
	if (reset || i_release) begin
		for (int i = 0; i < `COMPACT_LANES; i++) begin
			o_slots[i] <= '0;
		end
	end
	else if (do_write) begin
		o_slots[wr_ptr] <= i_elem;
	end
end

// with every lane nonzero the pointer wraps to 0 on the final write,
// which is harmless since the scan ends on that edge
always_ff @(posedge clk) begin
	if (reset || i_release) begin
		wr_ptr <= '0;
	end
	else if (do_write) begin
		wr_ptr <= wr_ptr + 1'b1;
	end
end

endmodule

// ==== source/sparse_compactor.sv ====
`timescale 1ns/1ps
`include "compact_config.svh"

module sparse_compactor
	import compact_pkg::*;
(
	clk,
	reset,
	i_in_valid,
	o_in_ready,
	i_act,
	i_wgt,
	o_out_valid,
	i_out_taken,
	o_act,
	o_wgt
);

input clk, reset;

// producer side
input i_in_valid;
output logic o_in_ready;
input elem_t i_act [`COMPACT_LANES];
input elem_t i_wgt [`COMPACT_LANES];

// consumer side
output logic o_out_valid;
input i_out_taken;
output elem_t o_act [`COMPACT_LANES];
output elem_t o_wgt [`COMPACT_LANES];

logic capture;
logic step;
logic release_pulse;
logic last;

idx_t scan_index;

elem_t act_elem;
elem_t wgt_elem;

scan_fsm fsm (
	.clk(clk),
	.reset(reset),
	.i_in_valid(i_in_valid),
	.i_out_taken(i_out_taken),
	.i_last(last),
	.o_in_ready(o_in_ready),
	.o_out_valid(o_out_valid),
	.o_capture(capture),
	.o_step(step),
	.o_release(release_pulse)
);

scan_counter counter (
	.clk(clk),
	.reset(reset),
	.i_clear(capture),
	.i_step(step),
	.o_index(scan_index),
	.o_last(last)
);

// both vectors share one scan index
operand_buffer act_buf (
	.clk(clk),
	.reset(reset),
	.i_capture(capture),
	.i_frame(i_act),
	.i_index(scan_index),
	.o_elem(act_elem)
);

operand_buffer wgt_buf (
	.clk(clk),
	.reset(reset),
	.i_capture(capture),
	.i_frame(i_wgt),
	.i_index(scan_index),
	.o_elem(wgt_elem)
);

// each vector keeps its own write pointer, so the packings differ
zero_compactor act_pack (
	.clk(clk),
	.reset(reset),
	.i_step(step),
	.i_release(release_pulse),
	.i_elem(act_elem),
	.o_slots(o_act)
);

zero_compactor wgt_pack (
	.clk(clk),
	.reset(reset),
	.i_step(step),
	.i_release(release_pulse),
	.i_elem(wgt_elem),
	.o_slots(o_wgt)
);

endmodule

// ==== bench/sparse_compactor_chk.sv ====
`timescale 1ns/1ps
`include "compact_config.svh"

module sparse_compactor_chk
	import compact_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic i_in_valid,
	input logic o_in_ready,
	input logic o_out_valid,
	input logic i_out_taken,
	input elem_t o_act [`COMPACT_LANES],
	input elem_t o_wgt [`COMPACT_LANES]
);

logic accept;
logic [ELEM_W*`COMPACT_LANES-1:0] act_flat; // all slots side by side
logic [ELEM_W*`COMPACT_LANES-1:0] wgt_flat;
int fail_count = 0; // failed assertions so far

assign accept = i_in_valid && o_in_ready;

always_comb begin
	for (int i = 0; i < `COMPACT_LANES; i++) begin
		act_flat[i*ELEM_W +: ELEM_W] = o_act[i];
		wgt_flat[i*ELEM_W +: ELEM_W] = o_wgt[i];
	end
end

ready_valid_exclusive: assert property (@(posedge clk) disable iff (reset)
	!(o_in_ready && o_out_valid))
	else begin
		$error("o_in_ready and o_out_valid are high together");
		fail_count++;
	end

// sampled values lag one edge and the rise lands between edges 16 and 17
valid_after_scan: assert property (@(posedge clk) disable iff (reset)
	accept |-> ##16 !o_out_valid ##1 o_out_valid)
	else begin
		$error("o_out_valid did not rise 16 cycles after acceptance");
		fail_count++;
	end

held_outputs_stable: assert property (@(posedge clk) disable iff (reset)
	(o_out_valid && !i_out_taken) |=> ($stable(act_flat) && $stable(wgt_flat)))
	else begin
		$error("outputs changed while the result was held");
		fail_count++;
	end

endmodule

// ==== bench/sparse_compactor_tb.sv ====
`timescale 1ns/1ps
`include "compact_config.svh"

module sparse_compactor_tb
	import compact_pkg::*;
();

localparam int LANES = `COMPACT_LANES;
localparam int NUM_TESTS = 7;
localparam int WATCHDOG_CYCLES = NUM_TESTS * 40;

typedef elem_t vec_t [LANES];

logic clk;
logic reset;
logic i_in_valid;
logic i_out_taken;
logic o_in_ready;
logic o_out_valid;
vec_t i_act;
vec_t i_wgt;
vec_t o_act;
vec_t o_wgt;
vec_t zero_vec;

int errors;
int tests_run;
int tests_bad;

sparse_compactor dut (.*);

bind sparse_compactor sparse_compactor_chk chk (
	.clk(clk),
	.reset(reset),
	.i_in_valid(i_in_valid),
	.o_in_ready(o_in_ready),
	.o_out_valid(o_out_valid),
	.i_out_taken(i_out_taken),
	.o_act(o_act),
	.o_wgt(o_wgt)
);

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

task automatic tick();
	@(posedge clk);
	#1; // drive and sample just after the edge
endtask

// nonzero elements move to the front in order and the rest read zero
task automatic pack_ref(input vec_t src, output vec_t dst);
	int n;
	n = 0;
	for (int i = 0; i < LANES; i++) dst[i] = '0;
	for (int i = 0; i < LANES; i++) begin
		if (src[i] != '0) begin
			dst[n] = src[i];
			n++;
		end
	end
endtask

function automatic elem_t rand_elem();
	elem_t v;
	if ($urandom % 2 == 0) return '0; // about half the lanes empty
	v = elem_t'($urandom);
	if (v == '0) v = 20'sd1;
	return v;
endfunction

task automatic check_vec(input string name, input string which, input vec_t exp, input vec_t got);
	for (int i = 0; i < LANES; i++) begin
		assert (got[i] === exp[i]) else begin
			$display("Mismatch %s %s[%0d]: expected %h, actual %h",
				name, which, i, exp[i], got[i]);
			errors++;
		end
	end
endtask

task automatic check_flag(input string name, input string what, input logic cond);
	assert (cond) else begin
		$display("%s: %s", name, what);
		errors++;
	end
endtask

task automatic send_frame(input string name, input vec_t act, input vec_t wgt);
	logic was_ready;
	int waited;
	waited = 0;
	i_act = act;
	i_wgt = wgt;
	i_in_valid = 1'b1;
	do begin
		was_ready = o_in_ready; // ready before the edge means taken at it
		tick();
		waited++;
	end while (!was_ready && waited < 40);
	i_in_valid = 1'b0;
	check_flag(name, "frame was never accepted", was_ready);
	check_flag(name, "o_in_ready stayed high after acceptance", !o_in_ready);
endtask

task automatic wait_result(input string name);
	int cycles;
	cycles = 0;
	while (!o_out_valid && cycles < 40) begin
		tick();
		cycles++;
	end
	assert (cycles == LANES) else begin
		$display("Mismatch %s latency: expected %0d, actual %0d", name, LANES, cycles);
		errors++;
	end
endtask

task automatic take_result(input string name);
	i_out_taken = 1'b1;
	tick();
	i_out_taken = 1'b0;
	check_flag(name, "o_in_ready low after release", o_in_ready);
	check_flag(name, "o_out_valid still high after release", !o_out_valid);
	check_vec(name, "o_act after release", zero_vec, o_act);
	check_vec(name, "o_wgt after release", zero_vec, o_wgt);
endtask

task automatic run_frame(input string name, input vec_t act, input vec_t wgt);
	vec_t exp_act;
	vec_t exp_wgt;
	pack_ref(act, exp_act);
	pack_ref(wgt, exp_wgt);
	send_frame(name, act, wgt);
	wait_result(name);
	check_vec(name, "o_act", exp_act, o_act);
	check_vec(name, "o_wgt", exp_wgt, o_wgt);
	take_result(name);
endtask

task automatic report(input string name, input int err_before);
	tests_run++;
	if (errors > err_before) begin
		tests_bad++;
		$display("%s: FAIL", name);
	end
	else begin
		$display("%s: ok", name);
	end
endtask

task automatic dense_frame();
	vec_t act;
	vec_t wgt;
	int e;
	e = errors;
	for (int i = 0; i < LANES; i++) begin
		act[i] = elem_t'(i + 1);
		wgt[i] = -elem_t'((i + 1) << 12);
	end
	run_frame("dense_frame", act, wgt);
	report("dense_frame", e);
endtask

task automatic fixed_sparse();
	vec_t act;
	vec_t wgt;
	int e;
	e = errors;
	act = zero_vec;
	wgt = zero_vec;
	act[1] = 20'sh10000; // 1.0
	act[4] = -20'sh08000;
	act[5] = 20'sh00001; // smallest step
	act[9] = 20'sh80000; // -8.0
	act[15] = 20'sh7ffff;
	wgt[0] = -20'sh00003;
	wgt[7] = 20'sh24000;
	wgt[8] = -20'sh10000;
	run_frame("fixed_sparse", act, wgt);
	report("fixed_sparse", e);
endtask

task automatic zero_frame();
	int e;
	e = errors;
	run_frame("zero_frame", zero_vec, zero_vec);
	report("zero_frame", e);
endtask

task automatic random_sparse(input string name);
	vec_t act;
	vec_t wgt;
	int e;
	e = errors;
	for (int i = 0; i < LANES; i++) begin
		act[i] = rand_elem();
		wgt[i] = rand_elem();
	end
	run_frame(name, act, wgt);
	report(name, e);
endtask

task automatic held_result();
	vec_t act1;
	vec_t wgt1;
	vec_t act2;
	vec_t wgt2;
	vec_t exp_act;
	vec_t exp_wgt;
	int e;
	e = errors;
	for (int i = 0; i < LANES; i++) begin
		act1[i] = rand_elem();
		wgt1[i] = rand_elem();
		act2[i] = rand_elem();
		wgt2[i] = rand_elem();
	end
	pack_ref(act1, exp_act);
	pack_ref(wgt1, exp_wgt);
	send_frame("held_result", act1, wgt1);
	wait_result("held_result");
	i_act = act2; // next frame offered while the consumer stalls
	i_wgt = wgt2;
	i_in_valid = 1'b1;
	repeat (10) begin
		tick();
		check_flag("held_result", "o_in_ready rose while result held", !o_in_ready);
		check_flag("held_result", "o_out_valid dropped without release", o_out_valid);
		check_vec("held_result", "o_act held", exp_act, o_act);
		check_vec("held_result", "o_wgt held", exp_wgt, o_wgt);
	end
	take_result("held_result");
	run_frame("held_result", act2, wgt2);
	report("held_result", e);
endtask

initial begin
	repeat (WATCHDOG_CYCLES) @(posedge clk);
	$display("watchdog expired after %0d cycles, the DUT stopped responding",
		WATCHDOG_CYCLES);
	$display("tests failed");
	$finish;
end

initial begin
	void'($urandom(32'hd64b8586));
	errors = 0;
	tests_run = 0;
	tests_bad = 0;
	reset = 1'b1;
	i_in_valid = 1'b0;
	i_out_taken = 1'b0;
	for (int i = 0; i < LANES; i++) begin
		zero_vec[i] = '0;
		i_act[i] = '0;
		i_wgt[i] = '0;
	end
	repeat (2) @(posedge clk);
	#1;
	reset = 1'b0;
	check_flag("reset", "o_in_ready low after reset", o_in_ready);
	check_flag("reset", "o_out_valid high after reset", !o_out_valid);
	check_vec("reset", "o_act", zero_vec, o_act);
	check_vec("reset", "o_wgt", zero_vec, o_wgt);
	dense_frame();
	fixed_sparse();
	zero_frame();
	random_sparse("random_sparse_0");
	random_sparse("random_sparse_1");
	random_sparse("random_sparse_2");
	held_result();
	$display("summary: %0d run, %0d failing, %0d check errors, %0d assertion failures",
		tests_run, tests_bad, errors, dut.chk.fail_count);
	if (errors == 0 && dut.chk.fail_count == 0) begin
		$display("all tests passed");
	end
	else begin
		$display("tests failed");
	end
	$finish;
end

endmodule

// ==== build.f ====
+incdir+source
source/compact_pkg.sv
source/scan_fsm.sv
source/scan_counter.sv
source/operand_buffer.sv
source/zero_compactor.sv
source/sparse_compactor.sv
bench/sparse_compactor_chk.sv
bench/sparse_compactor_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sparse compactor testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module sparse_compactor_tb \
	-f build.f -o sparse_compactor_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sparse_compactor_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
